// File: rtl/mp_cfg_pkg.sv
package mp_cfg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Port counts
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int num_rd = 2;
  localparam int num_wr = 4;

  // ~~~~~~~~~~~~~~~~~~~~
  // Word and address geometry
  // ~~~~~~~~~~~~~~~~~~~~
  localparam int data_w = 32;
  localparam int adr_w  = 8;

  // Upper address bits pick the bank, the rest pick the row
  localparam int bank_w   = 3;
  localparam int num_bank = 1 << bank_w;

  localparam int row_w   = adr_w - bank_w;
  localparam int num_row = 1 << row_w;

endpackage

// File: rtl/mp_bus_pkg.sv
package mp_bus_pkg;

  import mp_cfg_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~
  // Port requests
  // ~~~~~~~~~~~~~~~~~~~~

  // One write port, strobe plus address and data
  typedef struct packed {
    logic              valid;
    logic [adr_w-1:0]  adr;
    logic [data_w-1:0] data;
  } wr_req_t;

  // One read port, strobe plus address
  typedef struct packed {
    logic             valid;
    logic [adr_w-1:0] adr;
  } rd_req_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Port responses
  // ~~~~~~~~~~~~~~~~~~~~

  // Read result, valid one cycle after the strobe
  typedef struct packed {
    logic              valid;
    logic [data_w-1:0] data;
  } rd_rsp_t;

endpackage

// File: rtl/bank_sram.sv
`timescale 1ns/1ps

module bank_sram
  import mp_cfg_pkg::*, mp_bus_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              clearing,
  input  logic [row_w-1:0]  clear_row,
  input  logic              ready,
  input  wr_req_t           wr,
  input  rd_req_t           rd,
  output logic [data_w-1:0] rd_data
);

  logic [data_w-1:0] mem [num_row];

  logic [row_w-1:0] wr_row;
  logic [row_w-1:0] rd_row;

  assign wr_row = wr.adr[row_w-1:0];
  assign rd_row = rd.adr[row_w-1:0];

  // Read samples the old word, the write lands on the same edge
  always_ff @(posedge clk) begin
    if (rd.valid) begin
      rd_data <= mem[rd_row];
    end
  end

  // Init sweep has priority over the write port
  always_ff @(posedge clk) begin
    if (clearing) begin
      mem[clear_row] <= '0;
    end else if (wr.valid && ready) begin
      mem[wr_row] <= wr.data;
    end
  end

  // Sweep and normal traffic never overlap
  a_clear_excl_ready: assert property (
    @(posedge clk) disable iff (reset) !(clearing && ready)
  ) else $error("bank clear still active while ready is high");

endmodule

// File: rtl/bank_port_select.sv
`timescale 1ns/1ps

module bank_port_select
  import mp_cfg_pkg::*, mp_bus_pkg::*;
#(
  parameter type         req_t   = rd_req_t,
  parameter int          n_req   = num_rd,
  parameter int unsigned bank_id = 0
)
(
  input  logic clk,
  input  logic reset,
  input  req_t req [n_req],
  output req_t sel
);

  logic [n_req-1:0] hit;

  // ~~~~~~~~~~~~~~~~~~~~
  // Bank match per port
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int i = 0; i < n_req; i++) begin
      hit[i] = req[i].valid &&
               (req[i].adr[adr_w-1 -: bank_w] == bank_w'(bank_id));
    end
  end

  // Lowest index wins, sel stays idle when nothing targets this bank
  always_comb begin
    sel = '0;
    for (int i = n_req - 1; i >= 0; i--) begin
      if (hit[i]) begin
        sel = req[i];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Usage rule checks
  // ~~~~~~~~~~~~~~~~~~~~

  // Ports of one kind must spread over distinct banks each cycle
  for (genvar i = 1; i < n_req; i++) begin : g_chk
    for (genvar j = 0; j < i; j++) begin : g_pair
      a_bank_conflict: assert property (
        @(posedge clk) disable iff (reset) !(hit[i] && hit[j])
      ) else $error("bank %0d conflict between port %0d and port %0d",
                    bank_id, j, i);
    end
  end

endmodule

// File: rtl/mp_init_seq.sv
`timescale 1ns/1ps

module mp_init_seq
  import mp_cfg_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  output logic             clearing,
  output logic [row_w-1:0] clear_row,
  output logic             ready
);

  // Sweep is armed during reset so row 0 goes on the first free edge
  always_ff @(posedge clk) begin
    if (reset) begin
      clearing  <= 1'b1;
      clear_row <= '0;
      ready     <= 1'b0;
    end else if (clearing) begin
      clear_row <= clear_row + 1'b1;
      if (clear_row == row_w'(num_row - 1)) begin
        clearing <= 1'b0;
        ready    <= 1'b1;
      end
    end
  end

endmodule

// File: rtl/read_return.sv
`timescale 1ns/1ps

module read_return
  import mp_cfg_pkg::*, mp_bus_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              ready,
  input  rd_req_t           rd_req    [num_rd],
  input  logic [data_w-1:0] bank_data [num_bank],
  output rd_rsp_t           rd_rsp    [num_rd]
);

  logic              acc_q  [num_rd];
  logic [bank_w-1:0] bank_q [num_rd];

  // ~~~~~~~~~~~~~~~~~~~~
  // Request tracking
  // ~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int p = 0; p < num_rd; p++) begin
        acc_q[p] <= 1'b0;
      end
    end else begin
      for (int p = 0; p < num_rd; p++) begin
        acc_q[p] <= rd_req[p].valid && ready;
      end
    end
  end

  // Bank index only matters when acc_q is set
  always_ff @(posedge clk) begin
    for (int p = 0; p < num_rd; p++) begin
      bank_q[p] <= rd_req[p].adr[adr_w-1 -: bank_w];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Response mux
  // ~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    for (int p = 0; p < num_rd; p++) begin
      rd_rsp[p].valid = acc_q[p];
      rd_rsp[p].data  = bank_data[bank_q[p]];
    end
  end

endmodule

// File: rtl/mp_mem_top.sv
`timescale 1ns/1ps

module mp_mem_top
  import mp_cfg_pkg::*, mp_bus_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  wr_req_t wr_req [num_wr],
  input  rd_req_t rd_req [num_rd],
  output rd_rsp_t rd_rsp [num_rd],
  output logic    ready
);

  logic             clearing;
  logic [row_w-1:0] clear_row;

  wr_req_t           wr_sel    [num_bank];
  rd_req_t           rd_sel    [num_bank];
  logic [data_w-1:0] bank_data [num_bank];

  // ~~~~~~~~~~~~~~~~~~~~
  // Init sweep
  // ~~~~~~~~~~~~~~~~~~~~
  mp_init_seq u_init (
    .clk       (clk),
    .reset     (reset),
    .clearing  (clearing),
    .clear_row (clear_row),
    .ready     (ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Per bank selectors and storage
  // ~~~~~~~~~~~~~~~~~~~~
  for (genvar b = 0; b < num_bank; b++) begin : g_bank

    bank_port_select #(
      .req_t   (wr_req_t),
      .n_req   (num_wr),
      .bank_id (b)
    ) u_wr_sel (
      .clk   (clk),
      .reset (reset),
      .req   (wr_req),
      .sel   (wr_sel[b])
    );

    bank_port_select #(
      .req_t   (rd_req_t),
      .n_req   (num_rd),
      .bank_id (b)
    ) u_rd_sel (
      .clk   (clk),
      .reset (reset),
      .req   (rd_req),
      .sel   (rd_sel[b])
    );

    bank_sram u_sram (
      .clk       (clk),
      .reset     (reset),
      .clearing  (clearing),
      .clear_row (clear_row),
      .ready     (ready),
      .wr        (wr_sel[b]),
      .rd        (rd_sel[b]),
      .rd_data   (bank_data[b])
    );

  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Read data return
  // ~~~~~~~~~~~~~~~~~~~~
  read_return u_ret (
    .clk       (clk),
    .reset     (reset),
    .ready     (ready),
    .rd_req    (rd_req),
    .bank_data (bank_data),
    .rd_rsp    (rd_rsp)
  );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns = 8
) (
  output logic clk
);

  // Free running clock, low for the first half period
  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk;
    end
  end

endmodule

// File: verif/mp_mem_checks.sv
`timescale 1ns/1ps

module mp_mem_checks
  import mp_cfg_pkg::*, mp_bus_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  wr_req_t wr_req [num_wr],
  input  rd_req_t rd_req [num_rd],
  input  rd_rsp_t rd_rsp [num_rd],
  input  logic    ready,
  output logic    check_fail
);

  logic [data_w-1:0] shadow [num_bank * num_row];
  int                edge_cnt;
  logic              exp_ready;
  logic              exp_vld  [num_rd];
  logic [data_w-1:0] exp_data [num_rd];

  logic              ready_bad = 1'b0;
  logic [num_rd-1:0] vld_bad;
  logic [num_rd-1:0] data_bad;

  // ~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~

  // One row per edge after reset drops, ready once every row is done
  always_ff @(posedge clk) begin
    if (reset) begin
      edge_cnt <= 0;
    end else if (edge_cnt < num_row) begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  assign exp_ready = (edge_cnt == num_row);

  // Memory is all zero at ready, writes before that are dropped
  always_ff @(posedge clk) begin
    if (reset || !exp_ready) begin
      for (int a = 0; a < num_bank * num_row; a++) begin
        shadow[a] <= '0;
      end
    end else begin
      for (int w = 0; w < num_wr; w++) begin
        if (wr_req[w].valid) begin
          shadow[wr_req[w].adr] <= wr_req[w].data;
        end
      end
    end
  end

  // Read takes the word from before this edge's writes
  always_ff @(posedge clk) begin
    for (int p = 0; p < num_rd; p++) begin
      if (reset) begin
        exp_vld[p] <= 1'b0;
      end else begin
        exp_vld[p] <= rd_req[p].valid && exp_ready;
      end
      exp_data[p] <= shadow[rd_req[p].adr];
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Response checks
  // ~~~~~~~~~~~~~~~~~~~~
  a_ready_timing: assert property (
    @(posedge clk) disable iff (reset) ready == exp_ready
  ) else begin
    $display("FAILED ready: got %h, expected %h", $sampled(ready), $sampled(exp_ready));
    ready_bad = 1'b1;
  end

  for (genvar p = 0; p < num_rd; p++) begin : g_port
    logic vld_err  = 1'b0;
    logic data_err = 1'b0;

    assign vld_bad[p]  = vld_err;
    assign data_bad[p] = data_err;

    a_rsp_valid: assert property (
      @(posedge clk) disable iff (reset) rd_rsp[p].valid == exp_vld[p]
    ) else begin
      $display("FAILED rd_rsp[%0d].valid: got %h, expected %h",
               p, $sampled(rd_rsp[p].valid), $sampled(exp_vld[p]));
      vld_err = 1'b1;
    end

    a_rsp_data: assert property (
      @(posedge clk) disable iff (reset) exp_vld[p] |-> rd_rsp[p].data == exp_data[p]
    ) else begin
      $display("FAILED rd_rsp[%0d].data: got %h, expected %h",
               p, $sampled(rd_rsp[p].data), $sampled(exp_data[p]));
      data_err = 1'b1;
    end
  end

  assign check_fail = ready_bad | (|vld_bad) | (|data_bad);

endmodule

// File: verif/mp_mem_tb.sv
`timescale 1ns/1ps

module mp_mem_tb
  import mp_cfg_pkg::*, mp_bus_pkg::*;
();

  localparam int unsigned seed  = 32'h00b0_fe51;
  localparam int reset_cycles   = 16;
  localparam int n_zero_reads   = 16;
  localparam int n_directed     = 16;
  localparam int n_random       = 400;
  localparam int test_cycles    = n_zero_reads + n_directed + n_random;
  localparam int timeout_cycles = reset_cycles + num_row + test_cycles + 50;

  logic    clk;
  logic    reset;
  wr_req_t wr_req [num_wr];
  rd_req_t rd_req [num_rd];
  rd_rsp_t rd_rsp [num_rd];
  logic    ready;
  logic    check_fail;

  int bank_perm [num_bank];

  tb_clk_gen #(.period_ns(8)) u_clk (.clk(clk));

  mp_mem_top uut (
    .clk    (clk),
    .reset  (reset),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp),
    .ready  (ready)
  );

  mp_mem_checks u_checks (
    .clk        (clk),
    .reset      (reset),
    .wr_req     (wr_req),
    .rd_req     (rd_req),
    .rd_rsp     (rd_rsp),
    .ready      (ready),
    .check_fail (check_fail)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~
  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic idle_ports();
    for (int i = 0; i < num_wr; i++) begin
      wr_req[i] <= '0;
    end
    for (int p = 0; p < num_rd; p++) begin
      rd_req[p] <= '0;
    end
  endtask

  // Fisher-Yates over the bank indices
  task automatic shuffle_banks();
    int j;
    int t;
    for (int i = 0; i < num_bank; i++) begin
      bank_perm[i] = i;
    end
    for (int i = num_bank - 1; i > 0; i--) begin
      j = int'($urandom_range(i, 0));
      t = bank_perm[i];
      bank_perm[i] = bank_perm[j];
      bank_perm[j] = t;
    end
  endtask

  function automatic logic [adr_w-1:0] rand_adr(input int bank);
    logic [row_w-1:0] row;
    row = row_w'($urandom());
    return {bank_w'(bank), row};
  endfunction

  task automatic set_write(input int port, input logic [adr_w-1:0] adr,
                           input logic [data_w-1:0] data);
    wr_req[port] <= wr_req_t'{valid: 1'b1, adr: adr, data: data};
  endtask

  task automatic set_read(input int port, input logic [adr_w-1:0] adr);
    rd_req[port] <= rd_req_t'{valid: 1'b1, adr: adr};
  endtask

  // Reads sometimes reuse the write addresses to hit read-before-write
  task automatic drive_random(input int wr_pct, input int rd_pct);
    wr_req_t w [num_wr];
    logic    echo;
    shuffle_banks();
    for (int i = 0; i < num_wr; i++) begin
      w[i].valid = (int'($urandom_range(99, 0)) < wr_pct);
      w[i].adr   = rand_adr(bank_perm[i]);
      w[i].data  = $urandom();
      wr_req[i] <= w[i];
    end
    echo = ($urandom_range(3, 0) == 0);
    shuffle_banks();
    for (int p = 0; p < num_rd; p++) begin
      rd_req[p] <= rd_req_t'{valid: (int'($urandom_range(99, 0)) < rd_pct),
                             adr:   echo ? w[p].adr : rand_adr(bank_perm[p])};
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~
  initial begin : stimulus
    logic [adr_w-1:0] hit_adr [num_wr];
    void'($urandom(seed));
    idle_ports();
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    // Traffic during the sweep is dropped
    while (!ready) begin
      @(posedge clk);
      drive_random(50, 80);
    end

    repeat (n_zero_reads) begin
      @(posedge clk);
      idle_ports();
      shuffle_banks();
      for (int p = 0; p < num_rd; p++) begin
        set_read(p, rand_adr(bank_perm[p]));
      end
    end

    // All four write ports at once, then read back
    @(posedge clk);
    idle_ports();
    shuffle_banks();
    for (int w = 0; w < num_wr; w++) begin
      hit_adr[w] = rand_adr(bank_perm[w]);
      set_write(w, hit_adr[w], $urandom());
    end
    @(posedge clk);
    idle_ports();
    set_read(0, hit_adr[0]);
    set_read(1, hit_adr[1]);
    @(posedge clk);
    idle_ports();
    set_read(0, hit_adr[2]);
    set_read(1, hit_adr[3]);

    // Same address read and write in one cycle
    @(posedge clk);
    idle_ports();
    set_write(0, hit_adr[0], $urandom());
    set_read(0, hit_adr[0]);
    @(posedge clk);
    idle_ports();
    set_read(0, hit_adr[0]);

    @(posedge clk);
    idle_ports();
    shuffle_banks();
    set_read(0, rand_adr(bank_perm[0]));
    set_read(1, rand_adr(bank_perm[1]));
    @(posedge clk);
    idle_ports();
    set_read(1, rand_adr(bank_perm[2]));

    repeat (n_random) begin
      @(posedge clk);
      drive_random(50, 60);
    end
    @(posedge clk);
    idle_ports();
    repeat (3) @(posedge clk);

    if (check_fail) begin
      stop_with_failure("a check failed during the run");
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

  initial begin : check_watch
    @(posedge check_fail);
    stop_with_failure("stopping at the first failed check");
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    stop_with_failure("timeout: the test sequence did not finish within the cycle limit");
  end

endmodule

// File: src.f
rtl/mp_cfg_pkg.sv
rtl/mp_bus_pkg.sv
rtl/bank_sram.sv
rtl/bank_port_select.sv
rtl/mp_init_seq.sv
rtl/read_return.sv
rtl/mp_mem_top.sv
verif/tb_clk_gen.sv
verif/mp_mem_checks.sv
verif/mp_mem_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module mp_mem_tb \
  -f src.f \
  -o mp_mem_sim

output=$(./obj_dir/mp_mem_sim 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
  exit 0
else
  exit 1
fi
